//--- files.f
src/dct_fixed_pkg.sv
src/dct_coef_pkg.sv
src/dct_block_buffer.sv
src/dct_coef_mac.sv
src/dct_adder_tree.sv
src/dct_stage1.sv
sim/tb_dct_stage1.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the output for a pass.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_dct_stage1 -o tb_dct_stage1 \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_dct_stage1)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim/tb_dct_stage1.sv
`default_nettype none

module tb_dct_stage1;

  timeunit 1ns;
  timeprecision 1ps;

  import dct_fixed_pkg::*;
  import dct_coef_pkg::*;

  localparam int PX_WIDTH    = 8;
  localparam int OUT_W       = PX_WIDTH + 4 + COEF_FRACT_WIDTH;
  localparam int HALF_SCALE  = 1 << (PX_WIDTH - 1);
  localparam int CLK_PERIOD  = 4;
  localparam int MAX_ENTRIES = 40;

  logic                clk_i;
  logic                rst_i;
  logic                px_valid_i;
  logic [PX_WIDTH-1:0] px_data_i;
  logic                dct_valid_o;
  row_idx_t            dct_idx_o;
  logic [OUT_W-1:0]    dct_data_o;

  // pixel 0 of each table block sits in the top byte of its word.
  string       names [MAX_ENTRIES];
  logic [63:0] px_word [MAX_ENTRIES];
  int          gaps [MAX_ENTRIES];
  int          n_entries = 0;
  bit          table_ready = 1'b0;
  int          watchdog_cycles;
  int          seed = 32'h10b8c366;

  int          exp_data_q [$];
  row_idx_t    exp_idx_q [$];
  int          exp_entry_q [$];
  int          mismatches = 0;
  int          errors = 0;
  int          rows_checked = 0;

  int                      exp_data;
  row_idx_t                exp_idx;
  int                      exp_entry;
  logic signed [OUT_W-1:0] act_data;
  bit                      prev_valid;
  row_idx_t                prev_idx;

  dct_stage1 #(.PX_WIDTH(PX_WIDTH)) u_dct_stage1 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .px_valid_i  (px_valid_i),
    .px_data_i   (px_data_i),
    .dct_valid_o (dct_valid_o),
    .dct_idx_o   (dct_idx_o),
    .dct_data_o  (dct_data_o)
  );

  initial
    begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

  function automatic logic [7:0] pixel_of(input int e, input int j);
    return px_word[e][8*(7-j) +: 8];
  endfunction

  // sign-magnitude table entry as a signed integer in units of 2^-8.
  function automatic int coef_value(input coef_t c);
    int mag;
    mag = int'(c[COEF_FRACT_WIDTH-1:0]);
    return c[COEF_FRACT_WIDTH] ? -mag : mag;
  endfunction

  task automatic add_entry(input string name, input logic [63:0] pixels, input int gap);
    names[n_entries]   = name;
    px_word[n_entries] = pixels;
    gaps[n_entries]    = gap;
    n_entries++;
  endtask

  task automatic build_table();
    add_entry("flat", 64'h5A5A_5A5A_5A5A_5A5A, 0);
    add_entry("ramp", 64'h0024_496D_92B6_DBFF, 0);
    add_entry("alternate", 64'h00FF_00FF_00FF_00FF, 0);
    add_entry("all_zero", 64'h0000_0000_0000_0000, 0);
    add_entry("all_full", 64'hFFFF_FFFF_FFFF_FFFF, 0);
    for (int i = 0; i < 20; i++)
      add_entry($sformatf("random_%0d", i), {$random(seed), $random(seed)}, 0);
    // the same blocks again, now with idle cycles after every pixel.
    add_entry("ramp_gap2", px_word[1], 2);
    add_entry("alternate_gap3", px_word[2], 3);
    add_entry("random_0_gap1", px_word[5], 1);
    watchdog_cycles = 50;
    for (int e = 0; e < n_entries; e++)
      watchdog_cycles += BLOCK_LEN * (1 + gaps[e]);
  endtask

  // folds mirrored pixels and weights them with the signed table entries.
  task automatic predict_rows(input int e);
    int a;
    int b;
    int acc;
    for (int k = 0; k < BLOCK_LEN; k++)
      begin
        acc = 0;
        for (int j = 0; j < HALF_LEN; j++)
          begin
            a = int'(pixel_of(e, j)) - HALF_SCALE;
            b = int'(pixel_of(e, BLOCK_LEN - 1 - j)) - HALF_SCALE;
            acc += coef_value(COEFS[k][j]) * ((k % 2 == 0) ? (a + b) : (a - b));
          end
        exp_data_q.push_back(acc);
        exp_idx_q.push_back(row_idx_t'(k));
        exp_entry_q.push_back(e);
      end
  endtask

  task automatic send_block(input int e);
    predict_rows(e);
    for (int p = 0; p < BLOCK_LEN; p++)
      begin
        @(negedge clk_i);
        px_valid_i = 1'b1;
        px_data_i  = pixel_of(e, p);
        for (int g = 0; g < gaps[e]; g++)
          begin
            @(negedge clk_i);
            px_valid_i = 1'b0;
          end
      end
  endtask

  task automatic apply_reset();
    rst_i      = 1'b1;
    px_valid_i = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  task automatic report_counts();
    $display("checks done: %0d rows compared, %0d mismatches, %0d other errors",
             rows_checked, mismatches, errors);
  endtask

  // outputs are registered, so they are stable at the falling edge.
  always @(negedge clk_i)
    begin
      if (dct_valid_o)
        begin
          act_data = dct_data_o;
          if (exp_data_q.size() == 0)
            begin
              errors++;
              $display("an output row %0d appeared with no full block pending", dct_idx_o);
            end
          else
            begin
              exp_data  = exp_data_q.pop_front();
              exp_idx   = exp_idx_q.pop_front();
              exp_entry = exp_entry_q.pop_front();
              rows_checked++;
              if (dct_idx_o != exp_idx)
                begin
                  mismatches++;
                  $display("mismatch %s index: expected %0d, actual %0d",
                           names[exp_entry], exp_idx, dct_idx_o);
                end
              if (int'(act_data) != exp_data)
                begin
                  mismatches++;
                  $display("mismatch %s row %0d: expected %0d, actual %0d",
                           names[exp_entry], exp_idx, exp_data, int'(act_data));
                end
            end
          if (dct_idx_o != 0 && !(prev_valid && prev_idx == row_idx_t'(dct_idx_o - 1)))
            begin
              errors++;
              $display("row %0d did not follow the previous row in the next cycle", dct_idx_o);
            end
        end
      prev_valid = dct_valid_o;
      prev_idx   = dct_idx_o;
    end

  initial
    begin
      wait (table_ready);
      #(watchdog_cycles * CLK_PERIOD);
      errors++;
      $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
      report_counts();
      $display("SOME TESTS FAILED");
      $finish;
    end

  initial
    begin
      rst_i      = 1'b1;
      px_valid_i = 1'b0;
      px_data_i  = '0;
      build_table();
      table_ready = 1'b1;
      apply_reset();
      // five pixels of a partial block must not produce any row.
      for (int i = 0; i < 5; i++)
        begin
          @(negedge clk_i);
          px_valid_i = 1'b1;
          px_data_i  = PX_WIDTH'(40 * i);
        end
      @(negedge clk_i);
      px_valid_i = 1'b0;
      repeat (8) @(negedge clk_i);
      apply_reset();
      for (int e = 0; e < n_entries; e++)
        send_block(e);
      @(negedge clk_i);
      px_valid_i = 1'b0;
      while (exp_data_q.size() != 0)
        @(negedge clk_i);
      repeat (4) @(negedge clk_i);
      report_counts();
      if (mismatches == 0 && errors == 0)
        $display("ALL TESTS PASSED");
      else
        $display("SOME TESTS FAILED");
      $finish;
    end

endmodule

`default_nettype wire

//--- src/dct_adder_tree.sv
`default_nettype none

module dct_adder_tree #(
  parameter int PX_WIDTH = 8
)(
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  prod_valid_i,
  input  dct_fixed_pkg::row_idx_t               prod_idx_i,
  input  logic [dct_fixed_pkg::HALF_LEN-1:0]
               [PX_WIDTH+1+dct_fixed_pkg::COEF_FRACT_WIDTH:0] prod_i,
  output logic                                  dct_valid_o,
  output dct_fixed_pkg::row_idx_t               dct_idx_o,
  output logic [PX_WIDTH+3+dct_fixed_pkg::COEF_FRACT_WIDTH:0] dct_data_o
);

  import dct_fixed_pkg::*;

  localparam int PROD_W = PX_WIDTH + 2 + COEF_FRACT_WIDTH;
  localparam int PAIR_W = PROD_W + 1;
  localparam int OUT_W  = PX_WIDTH + 4 + COEF_FRACT_WIDTH;

  logic [HALF_LEN/2-1:0][PAIR_W-1:0] pair_q;
  logic                              pair_valid_q;
  row_idx_t                          pair_idx_q;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        pair_valid_q <= 1'b0;
        dct_valid_o  <= 1'b0;
      end
    else
      begin
        pair_valid_q <= prod_valid_i;
        dct_valid_o  <= pair_valid_q;
      end

  // lanes 0+1 and 2+3 first, then the two pair sums.
  always_ff @(posedge clk_i)
    begin
      pair_idx_q <= prod_idx_i;
      dct_idx_o  <= pair_idx_q;
      for (int p = 0; p < HALF_LEN / 2; p++)
        pair_q[p] <= PAIR_W'($signed(prod_i[2*p])) + PAIR_W'($signed(prod_i[2*p+1]));
      dct_data_o <= OUT_W'($signed(pair_q[0])) + OUT_W'($signed(pair_q[1]));
    end

endmodule

`default_nettype wire

//--- src/dct_block_buffer.sv
`default_nettype none

module dct_block_buffer #(
  parameter int PX_WIDTH = 8
)(
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          px_valid_i,
  input  logic [PX_WIDTH-1:0]                           px_data_i,
  output logic                                          block_start_o,
  output logic [dct_fixed_pkg::HALF_LEN-1:0][PX_WIDTH+1:0] sums_o,
  output logic [dct_fixed_pkg::HALF_LEN-1:0][PX_WIDTH+1:0] diffs_o
);

  import dct_fixed_pkg::*;

  localparam int SH_W       = PX_WIDTH + 1;
  localparam int BF_W       = PX_WIDTH + 2;
  localparam int HALF_SCALE = 2 ** (PX_WIDTH - 1);

  localparam row_idx_t LAST_POS = row_idx_t'(BLOCK_LEN - 1);

  // one of the two banks of level-shifted pixels fills while the other is read.
  logic [BLOCK_LEN-1:0][SH_W-1:0] bank_q [2];
  logic [BLOCK_LEN-1:0][SH_W-1:0] full_bank;
  logic [SH_W-1:0]                px_shift;
  row_idx_t                       pos_q;
  logic                           bank_sel_q;
  logic                           full_q;

  // centre the unsigned pixel around zero.
  assign px_shift = {1'b0, px_data_i} - SH_W'(HALF_SCALE);

  // the bank that is not being filled holds the last complete block.
  assign full_bank = bank_q[~bank_sel_q];

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        pos_q         <= '0;
        bank_sel_q    <= 1'b0;
        full_q        <= 1'b0;
        block_start_o <= 1'b0;
      end
    else
      begin
        full_q        <= px_valid_i && (pos_q == LAST_POS);
        block_start_o <= full_q;
        if (px_valid_i)
          begin
            pos_q <= pos_q + 1'b1;
            if (pos_q == LAST_POS)
              bank_sel_q <= ~bank_sel_q;
          end
      end

  // new pixels enter at the top, so pixel 0 of a block ends up at index 0.
  always_ff @(posedge clk_i)
    if (px_valid_i)
      bank_q[bank_sel_q] <= {px_shift, bank_q[bank_sel_q][BLOCK_LEN-1:1]};

  // fold mirrored positions into sums and differences once per block.
  always_ff @(posedge clk_i)
    if (full_q)
      for (int j = 0; j < HALF_LEN; j++)
        begin
          sums_o[j]  <= BF_W'($signed(full_bank[j])) +
                        BF_W'($signed(full_bank[BLOCK_LEN-1-j]));
          diffs_o[j] <= BF_W'($signed(full_bank[j])) -
                        BF_W'($signed(full_bank[BLOCK_LEN-1-j]));
        end

endmodule

`default_nettype wire

//--- src/dct_coef_mac.sv
`default_nettype none

module dct_coef_mac #(
  parameter int PX_WIDTH = 8
)(
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          block_start_i,
  input  logic [dct_fixed_pkg::HALF_LEN-1:0][PX_WIDTH+1:0] sums_i,
  input  logic [dct_fixed_pkg::HALF_LEN-1:0][PX_WIDTH+1:0] diffs_i,
  output logic                                          prod_valid_o,
  output dct_fixed_pkg::row_idx_t                       prod_idx_o,
  output logic [dct_fixed_pkg::HALF_LEN-1:0]
               [PX_WIDTH+1+dct_fixed_pkg::COEF_FRACT_WIDTH:0] prod_o
);

  import dct_fixed_pkg::*;
  import dct_coef_pkg::*;

  localparam int BF_W   = PX_WIDTH + 2;
  localparam int MAG_W  = BF_W - 1;
  localparam int PROD_W = PX_WIDTH + 2 + COEF_FRACT_WIDTH;

  localparam row_idx_t LAST_ROW = row_idx_t'(BLOCK_LEN - 1);

  row_idx_t                             row_q;
  row_idx_t                             row_sel;
  logic                                 busy_q;
  logic                                 issue;
  logic [HALF_LEN-1:0][BF_W-1:0]        lane_val;

  logic                                 op_valid_q;
  row_idx_t                             op_idx_q;
  logic [HALF_LEN-1:0]                  op_sign_q;
  logic [HALF_LEN-1:0][MAG_W-1:0]       op_mag_q;
  coef_t                                op_coef_q [HALF_LEN];

  logic [HALF_LEN-1:0]                  prod_sign_q;
  logic [HALF_LEN-1:0][PROD_W-2:0]      prod_mag_q;

  // row 0 goes out in the same cycle as the start pulse, then one row per cycle.
  assign row_sel = block_start_i ? '0 : row_q;
  assign issue   = block_start_i | busy_q;

  // even rows use the pair sums, odd rows the pair differences.
  always_comb
    for (int j = 0; j < HALF_LEN; j++)
      lane_val[j] = row_sel[0] ? diffs_i[j] : sums_i[j];

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        row_q        <= '0;
        busy_q       <= 1'b0;
        op_valid_q   <= 1'b0;
        prod_valid_o <= 1'b0;
      end
    else
      begin
        if (issue)
          begin
            row_q  <= row_sel + 1'b1;
            busy_q <= (row_sel != LAST_ROW);
          end
        op_valid_q   <= issue;
        prod_valid_o <= op_valid_q;
      end

  // the operand stage holds each lane's sign-magnitude value and its coefficient.
  always_ff @(posedge clk_i)
    if (issue)
      begin
        op_idx_q <= row_sel;
        for (int j = 0; j < HALF_LEN; j++)
          begin
            op_sign_q[j] <= lane_val[j][BF_W-1];
            op_mag_q[j]  <= lane_val[j][BF_W-1] ? MAG_W'(-lane_val[j])
                                                : lane_val[j][MAG_W-1:0];
            op_coef_q[j] <= COEFS[row_sel][j];
          end
      end

  // the coefficient is a pure fraction, so the raw product is already
  // in units of 2^-COEF_FRACT_WIDTH.
  always_ff @(posedge clk_i)
    begin
      prod_idx_o <= op_idx_q;
      for (int j = 0; j < HALF_LEN; j++)
        begin
          prod_sign_q[j] <= op_sign_q[j] ^ op_coef_q[j][COEF_FRACT_WIDTH];
          prod_mag_q[j]  <= op_mag_q[j] * op_coef_q[j][COEF_FRACT_WIDTH-1:0];
        end
    end

  // back to two's complement. negating a zero magnitude gives plain zero.
  always_comb
    for (int j = 0; j < HALF_LEN; j++)
      prod_o[j] = prod_sign_q[j] ? PROD_W'(-{1'b0, prod_mag_q[j]})
                                 : {1'b0, prod_mag_q[j]};

endmodule

`default_nettype wire

//--- src/dct_coef_pkg.sv
`default_nettype none

package dct_coef_pkg;

  import dct_fixed_pkg::*;

  // a sign-magnitude coefficient keeps its sign in the top bit and a pure fraction below.
  typedef logic [COEF_FRACT_WIDTH:0] coef_t;

  // builds a sign-magnitude entry from a signed integer in units of 2^-8.
  function automatic coef_t sm_coef(int val);
    logic neg;
    neg = (val < 0);
    sm_coef = {neg, COEF_FRACT_WIDTH'(neg ? -val : val)};
  endfunction

  // entry k, j is 256 * 0.5 * c(k) * cos((2j+1)k*pi/16) rounded to an integer.
  // even rows act on the pair sums and odd rows on the pair differences.
  localparam coef_t COEFS [BLOCK_LEN][HALF_LEN] = '{
    '{sm_coef(91),  sm_coef(91),   sm_coef(91),   sm_coef(91)},
    '{sm_coef(126), sm_coef(106),  sm_coef(71),   sm_coef(25)},
    '{sm_coef(118), sm_coef(49),   sm_coef(-49),  sm_coef(-118)},
    '{sm_coef(106), sm_coef(-25),  sm_coef(-126), sm_coef(-71)},
    '{sm_coef(91),  sm_coef(-91),  sm_coef(-91),  sm_coef(91)},
    '{sm_coef(71),  sm_coef(-126), sm_coef(25),   sm_coef(106)},
    '{sm_coef(49),  sm_coef(-118), sm_coef(118),  sm_coef(-49)},
    '{sm_coef(25),  sm_coef(-71),  sm_coef(106),  sm_coef(-126)}
  };

endpackage

`default_nettype wire

//--- src/dct_fixed_pkg.sv
`default_nettype none

package dct_fixed_pkg;

  // coefficients are pure fractions with this many bits below the point.
  localparam int COEF_FRACT_WIDTH = 8;

  // one block holds this many pixels and yields this many output rows.
  localparam int BLOCK_LEN = 8;

  // number of mirrored pixel pairs, which is also the number of multiplier lanes.
  localparam int HALF_LEN = BLOCK_LEN / 2;

  localparam int ROW_IDX_WIDTH = 3;

  // row index of an output coefficient, or position of a pixel inside its block.
  typedef logic [ROW_IDX_WIDTH-1:0] row_idx_t;

endpackage

`default_nettype wire

//--- src/dct_stage1.sv
`default_nettype none

module dct_stage1 #(
  parameter int PX_WIDTH = 8
)(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    px_valid_i,
  input  logic [PX_WIDTH-1:0]     px_data_i,
  output logic                    dct_valid_o,
  output dct_fixed_pkg::row_idx_t dct_idx_o,
  output logic [PX_WIDTH+3+dct_fixed_pkg::COEF_FRACT_WIDTH:0] dct_data_o
);

  import dct_fixed_pkg::*;

  logic                                                 block_start;
  logic [HALF_LEN-1:0][PX_WIDTH+1:0]                    sums;
  logic [HALF_LEN-1:0][PX_WIDTH+1:0]                    diffs;
  logic                                                 prod_valid;
  row_idx_t                                             prod_idx;
  logic [HALF_LEN-1:0][PX_WIDTH+1+COEF_FRACT_WIDTH:0]   prod;

  dct_block_buffer #(.PX_WIDTH(PX_WIDTH)) u_block_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .px_valid_i    (px_valid_i),
    .px_data_i     (px_data_i),
    .block_start_o (block_start),
    .sums_o        (sums),
    .diffs_o       (diffs)
  );

  dct_coef_mac #(.PX_WIDTH(PX_WIDTH)) u_coef_mac (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .block_start_i (block_start),
    .sums_i        (sums),
    .diffs_i       (diffs),
    .prod_valid_o  (prod_valid),
    .prod_idx_o    (prod_idx),
    .prod_o        (prod)
  );

  dct_adder_tree #(.PX_WIDTH(PX_WIDTH)) u_adder_tree (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .prod_valid_i  (prod_valid),
    .prod_idx_i    (prod_idx),
    .prod_i        (prod),
    .dct_valid_o   (dct_valid_o),
    .dct_idx_o     (dct_idx_o),
    .dct_data_o    (dct_data_o)
  );

endmodule

`default_nettype wire
